// File: Makefile
VERILATOR ?= verilator
TOP       := tb_l1_mem
FILELIST  := l1_mem.f
FLAGS     := --timing --assert --timescale 1ns/10ps
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Testbench failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/evict_write_buffer.sv
`timescale 1ns/10ps

// small FIFO of dirty lines from the dcache
// oldest entry is offered as a held write request
module evict_write_buffer #(
	parameter int EWB_DEPTH = 2
) (
	input logic clk,
	input logic rst,
	input logic wb_valid, // one-cycle pulse per dirty line
	input l1_mem_pkg::rv32i_word wb_addr,
	input l1_mem_pkg::mem_line wb_data,
	output logic wb_full,
	line_bus_if.requester drain
);
	import l1_mem_pkg::*;

	localparam int PTR_W = (EWB_DEPTH > 1) ? $clog2(EWB_DEPTH) : 1;
	localparam int CNT_W = $clog2(EWB_DEPTH + 1);

	rv32i_word addr_mem [EWB_DEPTH];
	mem_line   data_mem [EWB_DEPTH];

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;
	rv32i_word        line_addr;

	// circular increment
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(EWB_DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign line_addr = wb_addr & ~rv32i_word'(LINE_BYTES - 1); // align down
	assign push = wb_valid;
	assign pop  = drain.resp; // arbiter finished the head entry

	always_ff @(posedge clk) begin
		if (push) begin
			addr_mem[tail] <= line_addr;
			data_mem[tail] <= wb_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (push) begin
				tail <= ptr_next(tail);
			end
			if (pop) begin
				head <= ptr_next(head);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // both or neither, count unchanged
			endcase
		end
	end

	assign wb_full = (count == CNT_W'(EWB_DEPTH));

	assign drain.write = (count != '0);
	assign drain.addr  = addr_mem[head];
	assign drain.wdata = data_mem[head];

endmodule : evict_write_buffer

// File: hw/l1_arbiter.sv
`timescale 1ns/10ps

// shares one physical line port between icache, eviction buffer and dcache
// fixed priority: icache read, then writeback, then dcache read
module l1_arbiter (
	input logic clk,
	input logic rst,
	line_bus_if.server ic, // icache fill
	line_bus_if.server dc, // dcache fill
	line_bus_if.server wb, // eviction write buffer
	line_bus_if.requester pm // physical memory
);
	import l1_mem_pkg::*;

	typedef enum logic [2:0] {
		idle,
		read_a,  // icache selected
		read_b,  // dcache selected
		write_b, // writeback selected
		reading,
		writing,
		finish
	} state_t;

	state_t state;
	state_t next_state;

	rv32i_word addr_q;
	mem_line   wdata_q;
	mem_line   rdata_q;
	xact_kind  kind_q;

	rv32i_word sel_addr;
	xact_kind  sel_kind;
	logic      grant;

	// next state and the client picked in idle
	always_comb begin
		next_state = state;
		sel_addr = ic.addr;
		sel_kind = xact_ic_read;
		case (state)
			idle: begin
				if (ic.read) begin
					next_state = read_a;
				end else if (wb.write) begin
					// writeback ahead of dcache so a later fill sees the new line
					next_state = write_b;
					sel_addr = wb.addr;
					sel_kind = xact_wb;
				end else if (dc.read) begin
					next_state = read_b;
					sel_addr = dc.addr;
					sel_kind = xact_dc_read;
				end
			end
			read_a: next_state = reading;
			read_b: next_state = reading;
			write_b: next_state = writing;
			reading: begin
				if (pm.resp) begin
					next_state = finish;
				end
			end
			writing: begin
				if (pm.resp) begin
					next_state = finish;
				end
			end
			finish: next_state = idle;
			default: next_state = idle;
		endcase
	end

	assign grant = (state == idle) && (next_state != idle);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	// transaction registers, loaded on the edge that leaves idle
	always_ff @(posedge clk) begin
		if (grant) begin
			addr_q <= sel_addr;
			kind_q <= sel_kind;
			if (sel_kind == xact_wb) begin
				wdata_q <= wb.wdata;
			end
		end
	end

	// fill data kept until the next read completes
	always_ff @(posedge clk) begin
		if ((state == reading) && pm.resp) begin
			rdata_q <= pm.rdata;
		end
	end

	assign pm.read  = (state == reading);
	assign pm.write = (state == writing);
	assign pm.addr  = addr_q;
	assign pm.wdata = wdata_q;

	assign ic.rdata = rdata_q;
	assign dc.rdata = rdata_q;
	assign wb.rdata = '0; // nothing returns on the writeback channel

	// one resp pulse, steered by the latched kind
	always_comb begin
		ic.resp = 1'b0;
		dc.resp = 1'b0;
		wb.resp = 1'b0;
		if (state == finish) begin
			case (kind_q)
				xact_ic_read: ic.resp = 1'b1;
				xact_dc_read: dc.resp = 1'b1;
				xact_wb: wb.resp = 1'b1;
				default: ;
			endcase
		end
	end

endmodule : l1_arbiter

// File: hw/l1_mem_pkg.sv
package l1_mem_pkg;

	// fixed widths of the memory side
	localparam int WORD_BITS  = 32;
	localparam int LINE_BITS  = 256;
	localparam int LINE_BYTES = LINE_BITS / 8; // 32, lines aligned to this

	// byte address as seen by the core
	typedef logic [WORD_BITS-1:0] rv32i_word;

	// one cache line, 8 words
	typedef logic [LINE_BITS-1:0] mem_line;

	// transaction held by the arbiter while serving a client
	typedef enum logic [1:0] {
		xact_ic_read = 2'd0, // icache line fill
		xact_dc_read = 2'd1, // dcache line fill
		xact_wb      = 2'd2  // dirty line from the eviction buffer
	} xact_kind;

endpackage : l1_mem_pkg

// File: hw/l1_mem_top.sv
`timescale 1ns/10ps

// level-one memory subsystem: write buffer plus arbiter onto one line port
module l1_mem_top #(
	parameter int EWB_DEPTH = 2
) (
	input logic clk,
	input logic rst,

	input  logic                  ic_read,
	input  l1_mem_pkg::rv32i_word ic_addr,
	output l1_mem_pkg::mem_line   ic_rdata,
	output logic                  ic_resp,

	input  logic                  dc_read,
	input  l1_mem_pkg::rv32i_word dc_addr,
	output l1_mem_pkg::mem_line   dc_rdata,
	output logic                  dc_resp,

	input  logic                  wb_valid,
	input  l1_mem_pkg::rv32i_word wb_addr,
	input  l1_mem_pkg::mem_line   wb_data,
	output logic                  wb_full,

	output logic                  pmem_read,
	output logic                  pmem_write,
	output l1_mem_pkg::rv32i_word pmem_address,
	output l1_mem_pkg::mem_line   pmem_wdata,
	input  l1_mem_pkg::mem_line   pmem_rdata,
	input  logic                  pmem_resp
);

	line_bus_if ic_bus ();
	line_bus_if dc_bus ();
	line_bus_if wb_bus ();
	line_bus_if pm_bus ();

	// icache channel, read only
	assign ic_bus.read  = ic_read;
	assign ic_bus.write = 1'b0;
	assign ic_bus.addr  = ic_addr;
	assign ic_bus.wdata = '0;
	assign ic_rdata = ic_bus.rdata;
	assign ic_resp  = ic_bus.resp;

	// dcache channel, read only
	assign dc_bus.read  = dc_read;
	assign dc_bus.write = 1'b0;
	assign dc_bus.addr  = dc_addr;
	assign dc_bus.wdata = '0;
	assign dc_rdata = dc_bus.rdata;
	assign dc_resp  = dc_bus.resp;

	assign wb_bus.read = 1'b0; // buffer only ever writes

	// memory side, pins act as the server
	assign pmem_read    = pm_bus.read;
	assign pmem_write   = pm_bus.write;
	assign pmem_address = pm_bus.addr;
	assign pmem_wdata   = pm_bus.wdata;
	assign pm_bus.rdata = pmem_rdata;
	assign pm_bus.resp  = pmem_resp;

	evict_write_buffer #(
		.EWB_DEPTH(EWB_DEPTH)
	) u_ewb (
		.clk(clk),
		.rst(rst),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.wb_full(wb_full),
		.drain(wb_bus.requester)
	);

	l1_arbiter u_arbiter (
		.clk(clk),
		.rst(rst),
		.ic(ic_bus.server),
		.dc(dc_bus.server),
		.wb(wb_bus.server),
		.pm(pm_bus.requester)
	);

endmodule : l1_mem_top

// File: hw/line_bus_if.sv
`timescale 1ns/10ps

// one line-transfer channel
// request is a level held until the single-cycle resp
interface line_bus_if;
	import l1_mem_pkg::*;

	logic      read;
	logic      write;
	rv32i_word addr;  // stable while read or write is high
	mem_line   wdata;
	mem_line   rdata; // valid in the resp cycle
	logic      resp;

	modport requester (
		output read,
		output write,
		output addr,
		output wdata,
		input  rdata,
		input  resp
	);

	modport server (
		input  read,
		input  write,
		input  addr,
		input  wdata,
		output rdata,
		output resp
	);

endinterface : line_bus_if

// File: l1_mem.f
hw/l1_mem_pkg.sv
hw/line_bus_if.sv
hw/evict_write_buffer.sv
hw/l1_arbiter.sv
hw/l1_mem_top.sv
verif/l1_mem_asserts.sv
verif/tb_l1_mem.sv

// File: verif/l1_mem_asserts.sv
`timescale 1ns/10ps

// protocol checks on the arbiter, attached with bind
module l1_mem_asserts (
	input logic clk,
	input logic rst,
	input logic pm_read,
	input logic pm_write,
	input l1_mem_pkg::rv32i_word pm_addr,
	input l1_mem_pkg::mem_line pm_wdata,
	input logic ic_resp,
	input logic dc_resp,
	input logic wb_resp
);

	pm_one_kind: assert property (@(posedge clk) disable iff (rst) !(pm_read && pm_write))
		else $error("pm read and write high together");

	// request held, so address must hold too
	pm_addr_stable: assert property (@(posedge clk) disable iff (rst)
		$past(pm_read || pm_write) && (pm_read || pm_write) |-> $stable(pm_addr))
		else $error("pm address changed during a request");

	pm_wdata_stable: assert property (@(posedge clk) disable iff (rst)
		$past(pm_write) && pm_write |-> $stable(pm_wdata))
		else $error("pm write data changed during a write");

	resp_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({ic_resp, dc_resp, wb_resp}))
		else $error("more than one client resp at once");

	ic_pulse: assert property (@(posedge clk) disable iff (rst) ic_resp |=> !ic_resp)
		else $error("ic resp longer than one cycle");
	dc_pulse: assert property (@(posedge clk) disable iff (rst) dc_resp |=> !dc_resp)
		else $error("dc resp longer than one cycle");
	wb_pulse: assert property (@(posedge clk) disable iff (rst) wb_resp |=> !wb_resp)
		else $error("wb resp longer than one cycle");

endmodule : l1_mem_asserts

// File: verif/tb_l1_mem.sv
`timescale 1ns/10ps

module tb_l1_mem;
	import l1_mem_pkg::*;

	localparam int EWB_DEPTH = 2;
	localparam int CLK_NS = 4;
	localparam int N_IC = 150;
	localparam int N_DC = 250;
	localparam int N_XACT = N_IC + N_DC + 3 + EWB_DEPTH;
	localparam int SLOW_LAT = 12;
	// each transaction may wait behind two others of 3 + 6 cycles, doubled for margin
	localparam int WATCHDOG_NS = N_XACT * 3 * (3 + 6) * CLK_NS * 2;
	localparam logic [31:0] SEED = 32'd47646;

	logic clk = 1'b0;
	logic rst, ic_read, dc_read, wb_valid, pmem_resp;
	logic ic_resp, dc_resp, wb_full, pmem_read, pmem_write;
	rv32i_word ic_addr, dc_addr, wb_addr, pmem_address;
	mem_line ic_rdata, dc_rdata, wb_data, pmem_wdata, pmem_rdata;

	mem_line mem_arr [rv32i_word]; // memory contents
	mem_line ref_arr [rv32i_word]; // lines expected to be written
	rv32i_word wq_addr [$];        // writebacks not yet seen at memory
	mem_line wq_data [$];
	int wr_count;
	logic slow_mem;

	l1_mem_top #(.EWB_DEPTH(EWB_DEPTH)) dut (
		.clk(clk), .rst(rst),
		.ic_read(ic_read), .ic_addr(ic_addr), .ic_rdata(ic_rdata), .ic_resp(ic_resp),
		.dc_read(dc_read), .dc_addr(dc_addr), .dc_rdata(dc_rdata), .dc_resp(dc_resp),
		.wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data), .wb_full(wb_full),
		.pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
	);

	bind l1_arbiter l1_mem_asserts u_asserts (
		.clk(clk), .rst(rst), .pm_read(pm.read), .pm_write(pm.write),
		.pm_addr(pm.addr), .pm_wdata(pm.wdata),
		.ic_resp(ic.resp), .dc_resp(dc.resp), .wb_resp(wb.resp)
	);

	always #(CLK_NS / 2) clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic mem_line make_line(input logic [31:0] s);
		mem_line l;
		logic [31:0] t;
		t = s;
		for (int i = 0; i < 8; i++) begin
			t = lcg_step(t);
			l[i*32 +: 32] = t;
		end
		return l;
	endfunction

	function automatic rv32i_word line_base(input logic [2:0] idx);
		return 32'h0000_4000 + rv32i_word'(idx) * rv32i_word'(LINE_BYTES);
	endfunction

	// unwritten lines read back as their address repeated
	function automatic mem_line mem_contents(input rv32i_word a);
		return mem_arr.exists(a) ? mem_arr[a] : {8{a}};
	endfunction

	function automatic mem_line ref_contents(input rv32i_word a);
		return ref_arr.exists(a) ? ref_arr[a] : {8{a}};
	endfunction

	task automatic check_match(input string name, input mem_line got, input mem_line exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			$display("Testbench failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// wb_valid goes high at this edge until the caller drops it
	task automatic send_writeback(input rv32i_word line, input logic [4:0] offset,
		input mem_line d);
		wb_valid <= 1'b1;
		wb_addr <= line + rv32i_word'(offset);
		wb_data <= d;
		wq_addr.push_back(line);
		wq_data.push_back(d);
		ref_arr[line] = d;
	endtask

	// requests raised together are served icache first and dcache last with the new line
	task automatic order_test();
		int base;
		mem_line d;
		base = wr_count;
		d = make_line(SEED);
		@(posedge clk);
		ic_read <= 1'b1;
		ic_addr <= line_base(3'd1);
		dc_read <= 1'b1;
		dc_addr <= line_base(3'd3);
		send_writeback(line_base(3'd3), 5'd12, d);
		@(posedge clk);
		wb_valid <= 1'b0;
		do @(posedge clk); while (!ic_resp);
		check_match("writes before ic_resp", mem_line'(wr_count - base), '0);
		check_match("ic_rdata", ic_rdata, mem_contents(line_base(3'd1)));
		ic_read <= 1'b0;
		do @(posedge clk); while (!dc_resp);
		check_match("writes before dc_resp", mem_line'(wr_count - base), mem_line'(1));
		check_match("dc_rdata", dc_rdata, d);
		dc_read <= 1'b0;
	endtask

	task automatic full_test();
		slow_mem = 1'b1;
		for (int i = 0; i < EWB_DEPTH; i++) begin
			@(posedge clk);
			check_match("wb_full", mem_line'(wb_full), '0);
			send_writeback(line_base(3'(i + 4)), 5'd31, make_line(SEED + 32'(i)));
		end
		@(posedge clk);
		wb_valid <= 1'b0;
		@(posedge clk);
		check_match("wb_full", mem_line'(wb_full), mem_line'(1'b1));
		do @(posedge clk); while (wb_full); // first drain frees a slot
		slow_mem = 1'b0;
		while (wq_addr.size() != 0) @(posedge clk);
	endtask

	task automatic icache_client();
		logic [31:0] s;
		rv32i_word a;
		s = SEED ^ 32'h0000_1111;
		for (int n = 0; n < N_IC; n++) begin
			s = lcg_step(s);
			a = line_base(s[18:16]);
			repeat (s[1:0]) @(posedge clk); // idle gap
			@(posedge clk);
			ic_addr <= a;
			ic_read <= 1'b1;
			do @(posedge clk); while (!ic_resp);
			check_match("ic_rdata", ic_rdata, mem_contents(a));
			ic_read <= 1'b0;
		end
	endtask

	// dcache side mixes fills and writebacks in program order
	task automatic dcache_client();
		logic [31:0] s;
		rv32i_word a;
		s = SEED ^ 32'h0000_2222;
		for (int n = 0; n < N_DC; n++) begin
			s = lcg_step(s);
			a = line_base(s[18:16]);
			@(posedge clk);
			if (s[24]) begin
				while (wb_full) @(posedge clk);
				send_writeback(a, s[4:0], make_line(s));
				@(posedge clk);
				wb_valid <= 1'b0;
			end else begin
				dc_addr <= a;
				dc_read <= 1'b1;
				do @(posedge clk); while (!dc_resp);
				check_match("dc_rdata", dc_rdata, ref_contents(a));
				dc_read <= 1'b0;
			end
		end
	endtask

	initial begin : memory_model
		logic [31:0] s;
		int lat;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		wr_count = 0;
		s = SEED ^ 32'h0000_3333;
		forever begin
			@(posedge clk);
			if (!rst && (pmem_read || pmem_write)) begin
				s = lcg_step(s);
				lat = slow_mem ? SLOW_LAT : 1 + int'(s[31:16] % 16'd6);
				repeat (lat - 1) @(posedge clk);
				if (pmem_write && wq_addr.size() == 0) begin
					$display("memory write to %h with no writeback outstanding", pmem_address);
					$display("Testbench failed");
					$fatal(1, "unexpected memory write");
				end else begin
					if (pmem_write) begin
						check_match("pmem_address", mem_line'(pmem_address),
							mem_line'(wq_addr[0]));
						check_match("pmem_wdata", pmem_wdata, wq_data[0]);
						mem_arr[pmem_address] = pmem_wdata;
						wr_count++;
						void'(wq_addr.pop_front());
						void'(wq_data.pop_front());
					end else begin
						pmem_rdata <= mem_contents(pmem_address);
					end
					pmem_resp <= 1'b1;
					@(posedge clk);
					pmem_resp <= 1'b0;
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired before all transactions completed");
		$display("Testbench failed");
		$fatal(1, "timeout");
	end

	initial begin : main
		rst = 1'b1;
		ic_read = 1'b0;
		ic_addr = '0;
		dc_read = 1'b0;
		dc_addr = '0;
		wb_valid = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		slow_mem = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_match("outputs after reset",
			mem_line'({pmem_read, pmem_write, ic_resp, dc_resp, wb_full}), '0);
		order_test();
		full_test();
		fork
			icache_client();
			dcache_client();
		join
		while (wq_addr.size() != 0) @(posedge clk);
		repeat (4) @(posedge clk);
		foreach (ref_arr[a]) begin
			check_match($sformatf("memory line %h", a), mem_contents(a), ref_arr[a]);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule : tb_l1_mem
